// File: flist.f
hw/mips_pkg.sv
hw/decode_if.sv
hw/cpu_sequencer.sv
hw/instr_decode.sv
hw/alu.sv
hw/register_file.sv
hw/program_counter.sv
hw/mem_unit.sv
hw/mips_cpu_bus.sv
testbench/tb_clock_gen.sv
testbench/tb_avalon_mem.sv
testbench/tb_mips_cpu_bus.sv

// File: hw/alu.sv
module alu (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::cpu_state_t state,
    decode_if.sink               dec,
    input  mips_pkg::word_t      a,
    input  mips_pkg::word_t      b,
    output mips_pkg::word_t      result,
    output logic                 equal
);
    import mips_pkg::*;

    word_t op_b;
    word_t alu_out;

    // Immediate forms, including load and store address
    assign op_b = (dec.op inside {op_addiu, op_andi, op_ori, op_xori, op_lui,
                                  op_lw, op_lbu, op_sw, op_sb}) ? dec.imm : b;

    always_comb begin
        case (dec.op)
            op_addu, op_addiu, op_lw, op_lbu, op_sw, op_sb: alu_out = a + op_b;
            op_subu:        alu_out = a - op_b;
            op_and, op_andi: alu_out = a & op_b;
            op_or, op_ori:  alu_out = a | op_b;
            op_xor, op_xori: alu_out = a ^ op_b;
            op_slt:         alu_out = {31'b0, $signed(a) < $signed(op_b)};
            op_sltu:        alu_out = {31'b0, a < op_b};
            op_sll:         alu_out = b << dec.shamt;
            op_srl:         alu_out = b >> dec.shamt;
            op_sra:         alu_out = $signed(b) >>> dec.shamt;
            op_lui:         alu_out = {op_b[15:0], 16'h0000};
            default:        alu_out = '0;
        endcase
    end

    // Branch compare on rs and rt
    assign equal = (a == b);

    // Held through exec2, including data stalls
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            result <= '0;
        end else if (state == st_exec1) begin
            result <= alu_out;
        end
    end

endmodule

// File: hw/cpu_sequencer.sv
module cpu_sequencer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall,
    input  logic                 halt_jump,
    decode_if.sink               dec,
    output mips_pkg::cpu_state_t state,
    output logic                 reg_we,
    output logic                 pc_we,
    output logic                 active
);
    import mips_pkg::*;

    // Set when the jump to zero retires and cleared only by reset
    logic pending_halt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= st_fetch;
            pending_halt <= 1'b0;
        end else begin
            case (state)
                st_fetch: begin
                    if (!stall) begin
                        state <= st_exec1;
                    end
                end
                st_exec1: state <= st_exec2;
                st_exec2: begin
                    if (!stall) begin
                        if (pending_halt) begin
                            // Delay slot done
                            state <= st_halted;
                        end else begin
                            state <= st_fetch;
                            if (halt_jump) begin
                                pending_halt <= 1'b1;
                            end
                        end
                    end
                end
                default: state <= st_halted;
            endcase
        end
    end

    assign pc_we  = (state == st_exec1);
    assign reg_we = (state == st_exec2) && !stall && dec.writes_reg;
    assign active = (state != st_halted);

    // A halted core neither writes registers nor waits on the bus
    a_no_write_when_halted: assert property (
        @(posedge clk) disable iff (!rst_n)
        (state == st_halted) |-> (!reg_we && !stall)
    ) else $error("register write or bus stall while halted");

endmodule

// File: hw/decode_if.sv
interface decode_if;
    import mips_pkg::*;

    opcode_t        op;
    reg_idx_t       rs;
    reg_idx_t       rt;
    reg_idx_t       dest;
    logic [4:0]     shamt;
    // Already sign or zero extended
    word_t          imm;
    logic [25:0]    target;
    logic           writes_reg;

    modport source (output op, rs, rt, dest, shamt, imm, target, writes_reg);
    modport sink (input op, rs, rt, dest, shamt, imm, target, writes_reg);

endinterface

// File: hw/instr_decode.sv
module instr_decode (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_pkg::cpu_state_t state,
    input  mips_pkg::word_t      instr,
    decode_if.source             dec
);
    import mips_pkg::*;

    word_t   ir;
    opcode_t op;
    logic    is_rtype;
    logic    zero_ext;

    // Last write in fetch is the one where the read completes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ir <= '0;
        end else if (state == st_fetch) begin
            ir <= instr;
        end
    end

    assign is_rtype = (ir[31:26] == 6'h00);

    always_comb begin
        op = op_illegal;
        case (ir[31:26])
            6'h00: begin
                case (ir[5:0])
                    6'h00: op = op_sll;
                    6'h02: op = op_srl;
                    6'h03: op = op_sra;
                    6'h08: op = op_jr;
                    6'h21: op = op_addu;
                    6'h23: op = op_subu;
                    6'h24: op = op_and;
                    6'h25: op = op_or;
                    6'h26: op = op_xor;
                    6'h2a: op = op_slt;
                    6'h2b: op = op_sltu;
                    default: op = op_illegal;
                endcase
            end
            6'h02: op = op_j;
            6'h03: op = op_jal;
            6'h04: op = op_beq;
            6'h05: op = op_bne;
            6'h09: op = op_addiu;
            6'h0c: op = op_andi;
            6'h0d: op = op_ori;
            6'h0e: op = op_xori;
            6'h0f: op = op_lui;
            6'h23: op = op_lw;
            6'h24: op = op_lbu;
            6'h28: op = op_sb;
            6'h2b: op = op_sw;
            default: op = op_illegal;
        endcase
    end

    // Logic immediates are zero extended
    assign zero_ext = op inside {op_andi, op_ori, op_xori, op_lui};

    assign dec.op     = op;
    assign dec.rs     = ir[25:21];
    assign dec.rt     = ir[20:16];
    assign dec.shamt  = ir[10:6];
    assign dec.target = ir[25:0];
    assign dec.imm    = zero_ext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};
    assign dec.dest   = (op == op_jal) ? reg_ra : (is_rtype ? ir[15:11] : ir[20:16]);
    assign dec.writes_reg = !(op inside {op_beq, op_bne, op_j, op_jr, op_sw, op_sb, op_illegal});

endmodule

// File: hw/mem_unit.sv
module mem_unit (
    input  mips_pkg::cpu_state_t state,
    decode_if.sink               dec,
    input  mips_pkg::word_t      pc,
    input  mips_pkg::word_t      result,
    input  mips_pkg::word_t      link,
    input  mips_pkg::word_t      store_data,
    input  mips_pkg::word_t      readdata,
    input  logic                 waitrequest,
    output mips_pkg::word_t      address,
    output mips_pkg::word_t      writedata,
    output logic                 read,
    output logic                 write,
    output logic                 stall,
    output logic [3:0]           byteenable,
    output mips_pkg::word_t      load_data,
    output mips_pkg::word_t      instr
);
    import mips_pkg::*;

    logic       is_load;
    logic       is_store;
    logic       is_byte;
    logic [1:0] offset;
    word_t      rdata_be;
    word_t      wdata_be;
    logic [7:0] load_byte;

    // Bus lanes are little endian, the core is big endian
    function automatic word_t swap_lanes(input word_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

    assign is_load  = dec.op inside {op_lw, op_lbu};
    assign is_store = dec.op inside {op_sw, op_sb};
    assign is_byte  = dec.op inside {op_lbu, op_sb};
    assign offset   = result[1:0];

    assign read  = (state == st_fetch) || (state == st_exec2 && is_load);
    assign write = (state == st_exec2) && is_store;
    assign stall = (read || write) && waitrequest;

    assign address = (state == st_fetch) ? pc : {result[31:2], 2'b00};

    always_comb begin
        if (state != st_fetch && is_byte) begin
            byteenable = 4'b0001 << offset;
        end else begin
            byteenable = 4'b1111;
        end
    end

    // Byte stores go to every lane, byteenable picks one
    assign wdata_be  = is_byte ? {4{store_data[7:0]}} : store_data;
    assign writedata = swap_lanes(wdata_be);

    assign rdata_be  = swap_lanes(readdata);
    assign instr     = rdata_be;
    assign load_byte = rdata_be[8 * (3 - offset) +: 8];

    // Register write data
    always_comb begin
        case (dec.op)
            op_lw:   load_data = rdata_be;
            op_lbu:  load_data = {24'h000000, load_byte};
            op_jal:  load_data = link;
            default: load_data = result;
        endcase
    end

    a_one_strobe: assert final (!(read && write))
        else $error("read and write asserted together");

endmodule

// File: hw/mips_cpu_bus.sv
module mips_cpu_bus (
    input  logic            clk,
    input  logic            rst_n,
    output logic            active,
    output mips_pkg::word_t register_v0,

    // Avalon-MM master
    output mips_pkg::word_t address,
    output logic            read,
    output logic            write,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);
    import mips_pkg::*;

    cpu_state_t state;
    logic       stall;
    logic       halt_jump;
    logic       reg_we;
    logic       pc_we;
    logic       equal;
    word_t      rs_data;
    word_t      rt_data;
    word_t      alu_result;
    word_t      pc;
    word_t      link;
    word_t      load_data;
    word_t      instr;

    decode_if dec_bus ();

    cpu_sequencer u_sequencer (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .halt_jump (halt_jump),
        .dec       (dec_bus.sink),
        .state     (state),
        .reg_we    (reg_we),
        .pc_we     (pc_we),
        .active    (active)
    );

    instr_decode u_decode (
        .clk   (clk),
        .rst_n (rst_n),
        .state (state),
        .instr (instr),
        .dec   (dec_bus.source)
    );

    alu u_alu (
        .clk    (clk),
        .rst_n  (rst_n),
        .state  (state),
        .dec    (dec_bus.sink),
        .a      (rs_data),
        .b      (rt_data),
        .result (alu_result),
        .equal  (equal)
    );

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (reg_we),
        .ra_idx  (dec_bus.rs),
        .rb_idx  (dec_bus.rt),
        .wr_idx  (dec_bus.dest),
        .wr_data (load_data),
        .ra_data (rs_data),
        .rb_data (rt_data),
        .v0      (register_v0)
    );

    program_counter u_pc (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc_we     (pc_we),
        .dec       (dec_bus.sink),
        .equal     (equal),
        .rs_data   (rs_data),
        .pc        (pc),
        .link      (link),
        .halt_jump (halt_jump)
    );

    mem_unit u_mem (
        .state       (state),
        .dec         (dec_bus.sink),
        .pc          (pc),
        .result      (alu_result),
        .link        (link),
        .store_data  (rt_data),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .address     (address),
        .writedata   (writedata),
        .read        (read),
        .write       (write),
        .stall       (stall),
        .byteenable  (byteenable),
        .load_data   (load_data),
        .instr       (instr)
    );

endmodule

// File: hw/mips_pkg.sv
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Internal opcode, independent of the MIPS encoding
    typedef enum logic [5:0] {
        op_illegal,
        op_addu,
        op_addiu,
        op_subu,
        op_and,
        op_andi,
        op_or,
        op_ori,
        op_xor,
        op_xori,
        op_slt,
        op_sltu,
        op_sll,
        op_srl,
        op_sra,
        op_lui,
        op_lw,
        op_lbu,
        op_sw,
        op_sb,
        op_beq,
        op_bne,
        op_j,
        op_jal,
        op_jr
    } opcode_t;

    typedef enum logic [1:0] {
        st_fetch,
        st_exec1,
        st_exec2,
        st_halted
    } cpu_state_t;

    // First fetch address after reset
    localparam word_t reset_vector = 32'hBFC0_0000;

    // v0 holds the visible result, ra the JAL link
    localparam reg_idx_t reg_v0 = 5'd2;
    localparam reg_idx_t reg_ra = 5'd31;

endpackage

// File: hw/program_counter.sv
module program_counter (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            pc_we,
    decode_if.sink          dec,
    input  logic            equal,
    input  mips_pkg::word_t rs_data,
    output mips_pkg::word_t pc,
    output mips_pkg::word_t link,
    output logic            halt_jump
);
    import mips_pkg::*;

    word_t next_pc;
    word_t pc_plus4;
    word_t branch_target;
    word_t jump_target;
    word_t after_next;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {dec.imm[29:0], 2'b00};
    assign jump_target   = {pc_plus4[31:28], dec.target, 2'b00};

    // Target takes effect after the delay slot
    always_comb begin
        case (dec.op)
            op_beq:        after_next = equal ? branch_target : next_pc + 32'd4;
            op_bne:        after_next = equal ? next_pc + 32'd4 : branch_target;
            op_j, op_jal:  after_next = jump_target;
            op_jr:         after_next = rs_data;
            default:       after_next = next_pc + 32'd4;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= reset_vector;
            next_pc <= reset_vector + 32'd4;
            link    <= '0;
        end else if (pc_we) begin
            pc      <= next_pc;
            next_pc <= after_next;
            link    <= pc + 32'd8;
        end
    end

    assign halt_jump = (next_pc == '0);

endmodule

// File: hw/register_file.sv
module register_file (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               we,
    input  mips_pkg::reg_idx_t ra_idx,
    input  mips_pkg::reg_idx_t rb_idx,
    input  mips_pkg::reg_idx_t wr_idx,
    input  mips_pkg::word_t    wr_data,
    output mips_pkg::word_t    ra_data,
    output mips_pkg::word_t    rb_data,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    word_t regs [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wr_idx != '0) begin
            regs[wr_idx] <= wr_data;
        end
    end

    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];
    assign v0      = regs[reg_v0];

    a_zero_stays_zero: assert property (
        @(posedge clk) disable iff (!rst_n)
        we |=> (regs[0] == '0)
    ) else $error("register zero was written");

endmodule

// File: testbench/tb_avalon_mem.sv
module tb_avalon_mem (
    input  logic            clk,
    input  logic            stall_en,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    input  logic [3:0]      byteenable,
    output logic            waitrequest,
    output mips_pkg::word_t readdata,
    output logic            bus_error
);
    import mips_pkg::*;

    localparam int          depth = 256;
    localparam logic [31:0] seed  = 32'h7ad7_aa79;

    // Only the low address bits decode, so the reset vector lands on word 0
    word_t       mem [depth];
    logic [31:0] rng;
    logic        held;
    logic        held_read;
    logic        held_write;
    word_t       held_addr;
    word_t       held_wdata;
    logic [3:0]  held_be;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic fill_pattern();
        for (int i = 0; i < depth; i++) begin
            mem[i] = i * 32'h9e37_79b9;
        end
    endtask

    // Byte at the lowest address goes on lane 0
    task automatic load_word(input int i, input word_t w);
        mem[i] = {w[7:0], w[15:8], w[23:16], w[31:24]};
    endtask

    task automatic flag_error(input string msg);
        $display("memory model error at time %0t: %s", $time, msg);
        bus_error = 1'b1;
    endtask

    initial begin
        waitrequest = 1'b0;
        readdata    = '0;
        bus_error   = 1'b0;
        rng         = seed;
        held        = 1'b0;
    end

    // Decide each transfer on the falling edge, the DUT samples on the rising one
    always @(negedge clk) begin
        if (held) begin
            assert (read == held_read && write == held_write && address == held_addr &&
                    byteenable == held_be && (!write || writedata == held_wdata))
                else flag_error("address, strobes or write data changed during a stall");
        end
        held        = 1'b0;
        waitrequest = 1'b0;
        if (read || write) begin
            assert (!(read && write))
                else flag_error("read and write are high together");
            assert (address[1:0] == 2'b00)
                else flag_error("bus address is not word aligned");
            assert (!write || byteenable inside {4'b1111, 4'b0001, 4'b0010, 4'b0100, 4'b1000})
                else flag_error("write byteenable is neither a full word nor one byte");
            rng = xorshift(rng);
            if (stall_en && rng[0]) begin
                waitrequest = 1'b1;
                held        = 1'b1;
                held_read   = read;
                held_write  = write;
                held_addr   = address;
                held_wdata  = writedata;
                held_be     = byteenable;
            end else if (read) begin
                readdata = mem[address[9:2]];
            end else begin
                for (int k = 0; k < 4; k++) begin
                    if (byteenable[k]) begin
                        mem[address[9:2]][8 * k +: 8] = writedata[8 * k +: 8];
                    end
                end
            end
        end
    end

endmodule

// File: testbench/tb_clock_gen.sv
module tb_clock_gen (
    output logic clk,
    output logic rst_n
);
    localparam int half_period  = 20;
    localparam int reset_cycles = 16;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        forever #half_period clk = ~clk;
    end

    // Assert and release on falling edges
    task automatic apply_reset();
        @(negedge clk);
        rst_n = 1'b0;
        repeat (reset_cycles) @(negedge clk);
        rst_n = 1'b1;
    endtask

endmodule

// File: testbench/tb_mips_cpu_bus.sv
module tb_mips_cpu_bus;
    import mips_pkg::*;

    localparam int num_tests    = 5;
    localparam int prog_words   = 16;
    localparam int halt_timeout = 2000;
    localparam int quiet_cycles = 50;

    // MIPS32 primary opcodes
    localparam logic [5:0] opc_j     = 6'h02;
    localparam logic [5:0] opc_jal   = 6'h03;
    localparam logic [5:0] opc_beq   = 6'h04;
    localparam logic [5:0] opc_bne   = 6'h05;
    localparam logic [5:0] opc_addiu = 6'h09;
    localparam logic [5:0] opc_andi  = 6'h0c;
    localparam logic [5:0] opc_ori   = 6'h0d;
    localparam logic [5:0] opc_xori  = 6'h0e;
    localparam logic [5:0] opc_lui   = 6'h0f;
    localparam logic [5:0] opc_lw    = 6'h23;
    localparam logic [5:0] opc_lbu   = 6'h24;
    localparam logic [5:0] opc_sb    = 6'h28;
    localparam logic [5:0] opc_sw    = 6'h2b;

    // Function codes of the special opcode
    localparam logic [5:0] fn_sll  = 6'h00;
    localparam logic [5:0] fn_srl  = 6'h02;
    localparam logic [5:0] fn_sra  = 6'h03;
    localparam logic [5:0] fn_jr   = 6'h08;
    localparam logic [5:0] fn_addu = 6'h21;
    localparam logic [5:0] fn_subu = 6'h23;
    localparam logic [5:0] fn_and  = 6'h24;
    localparam logic [5:0] fn_or   = 6'h25;
    localparam logic [5:0] fn_xor  = 6'h26;
    localparam logic [5:0] fn_slt  = 6'h2a;
    localparam logic [5:0] fn_sltu = 6'h2b;

    localparam reg_idx_t r_zero = 5'd0;
    localparam reg_idx_t r_t0   = 5'd8;
    localparam reg_idx_t r_t1   = 5'd9;
    localparam reg_idx_t r_t2   = 5'd10;
    localparam reg_idx_t r_t3   = 5'd11;
    localparam reg_idx_t r_t4   = 5'd12;
    localparam reg_idx_t r_t5   = 5'd13;
    localparam reg_idx_t r_t6   = 5'd14;

    logic       clk;
    logic       rst_n;
    logic       stall_en;
    logic       waitrequest;
    logic       bus_error;
    logic       active;
    logic       read;
    logic       write;
    logic [3:0] byteenable;
    word_t      readdata;
    word_t      address;
    word_t      writedata;
    word_t      register_v0;

    // Program image and expected v0 per entry
    word_t prog [num_tests][prog_words];
    word_t expected_v0 [num_tests];
    int    cur_test;
    int    cur_word;

    tb_clock_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    tb_avalon_mem u_mem (
        .clk         (clk),
        .stall_en    (stall_en),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .waitrequest (waitrequest),
        .readdata    (readdata),
        .bus_error   (bus_error)
    );

    mips_cpu_bus i_mips_cpu_bus (
        .clk         (clk),
        .rst_n       (rst_n),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    function automatic word_t r_op(input logic [5:0] fn, input reg_idx_t rd, input reg_idx_t rs,
                                   input reg_idx_t rt, input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, fn};
    endfunction

    function automatic word_t i_op(input logic [5:0] opc, input reg_idx_t rt, input reg_idx_t rs,
                                   input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic word_t j_op(input logic [5:0] opc, input word_t dest);
        return {opc, dest[27:2]};
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic start_program(input int t, input word_t exp);
        cur_test       = t;
        cur_word       = 0;
        expected_v0[t] = exp;
    endtask

    task automatic emit(input word_t w);
        prog[cur_test][cur_word] = w;
        cur_word++;
    endtask

    task automatic build_table();
        for (int t = 0; t < num_tests; t++) begin
            for (int i = 0; i < prog_words; i++) begin
                prog[t][i] = '0;
            end
        end
        // Arithmetic and logic chain
        start_program(0, 32'h1235_70ef);
        emit(i_op(opc_lui, r_t0, r_zero, 16'h1234));
        emit(i_op(opc_ori, r_t0, r_t0, 16'hf0f0));
        emit(i_op(opc_addiu, r_t1, r_zero, 16'hffff));
        emit(r_op(fn_addu, r_t2, r_t0, r_t1, 5'd0));
        emit(i_op(opc_andi, r_t1, r_t2, 16'hff00));
        emit(r_op(fn_subu, r_t2, r_t2, r_t1, 5'd0));
        emit(i_op(opc_xori, r_t2, r_t2, 16'h00ff));
        emit(r_op(fn_and, r_t1, r_t0, r_t2, 5'd0));
        emit(r_op(fn_xor, r_t1, r_t1, r_t0, 5'd0));
        emit(r_op(fn_or, reg_v0, r_t1, r_t2, 5'd0));
        emit(i_op(opc_addiu, reg_v0, reg_v0, 16'h7fff));
        emit(r_op(fn_jr, r_zero, r_zero, r_zero, 5'd0));
        emit('0);
        // Compares and shifts with one more shift in the halt delay slot
        start_program(1, 32'h0000_1f10);
        emit(i_op(opc_addiu, r_t0, r_zero, 16'hfff8));
        emit(i_op(opc_addiu, r_t1, r_zero, 16'h0003));
        emit(r_op(fn_slt, r_t2, r_t0, r_t1, 5'd0));
        emit(r_op(fn_sltu, r_t3, r_t0, r_t1, 5'd0));
        emit(r_op(fn_sltu, r_t4, r_t1, r_t0, 5'd0));
        emit(r_op(fn_sll, r_t2, r_zero, r_t2, 5'd4));
        emit(r_op(fn_sll, r_t4, r_zero, r_t4, 5'd8));
        emit(r_op(fn_sra, r_t5, r_zero, r_t0, 5'd2));
        emit(r_op(fn_srl, r_t6, r_zero, r_t0, 5'd24));
        emit(r_op(fn_addu, reg_v0, r_t2, r_t3, 5'd0));
        emit(r_op(fn_addu, reg_v0, reg_v0, r_t4, 5'd0));
        emit(r_op(fn_xor, reg_v0, reg_v0, r_t6, 5'd0));
        emit(r_op(fn_subu, reg_v0, reg_v0, r_t5, 5'd0));
        emit(r_op(fn_jr, r_zero, r_zero, r_zero, 5'd0));
        emit(r_op(fn_sll, reg_v0, r_zero, reg_v0, 5'd4));
        // Taken BEQ, untaken BNE, JAL with JR ra, and J
        // v0 collects one bit per executed path and then adds ra
        start_program(2, 32'hbfc0_00a5);
        emit(i_op(opc_addiu, r_t0, r_zero, 16'h0005));
        emit(i_op(opc_addiu, r_t1, r_zero, 16'h0005));
        emit(i_op(opc_beq, r_t1, r_t0, 16'h0002));
        emit(i_op(opc_ori, reg_v0, reg_v0, 16'h0001));
        emit(i_op(opc_ori, reg_v0, reg_v0, 16'h0002));
        emit(i_op(opc_bne, r_t1, r_t0, 16'h0002));
        emit(i_op(opc_ori, reg_v0, reg_v0, 16'h0004));
        emit(i_op(opc_ori, reg_v0, reg_v0, 16'h0008));
        emit(j_op(opc_jal, reset_vector + 32'd48));
        emit(i_op(opc_ori, reg_v0, reg_v0, 16'h0010));
        emit(j_op(opc_j, reset_vector + 32'd56));
        emit(i_op(opc_ori, reg_v0, reg_v0, 16'h0020));
        emit(r_op(fn_jr, r_zero, reg_ra, r_zero, 5'd0));
        emit(i_op(opc_ori, reg_v0, reg_v0, 16'h0040));
        emit(r_op(fn_jr, r_zero, r_zero, r_zero, 5'd0));
        emit(r_op(fn_addu, reg_v0, reg_v0, reg_ra, 5'd0));
        // Untaken BEQ, taken BNE, then a backward loop of two passes
        start_program(3, 32'h0000_0870);
        emit(i_op(opc_addiu, r_t0, r_zero, 16'h0001));
        emit(i_op(opc_addiu, r_t1, r_zero, 16'h0002));
        emit(i_op(opc_beq, r_t1, r_t0, 16'h0003));
        emit(i_op(opc_addiu, reg_v0, reg_v0, 16'h0010));
        emit(i_op(opc_addiu, reg_v0, reg_v0, 16'h0020));
        emit(i_op(opc_bne, r_t1, r_t0, 16'h0003));
        emit(i_op(opc_addiu, reg_v0, reg_v0, 16'h0040));
        emit(i_op(opc_addiu, reg_v0, reg_v0, 16'h0100));
        emit(i_op(opc_addiu, reg_v0, reg_v0, 16'h0200));
        emit(i_op(opc_addiu, r_t2, r_t2, 16'h0001));
        emit(i_op(opc_bne, r_t1, r_t2, 16'hfffe));
        emit(i_op(opc_addiu, reg_v0, reg_v0, 16'h0400));
        emit(r_op(fn_jr, r_zero, r_zero, r_zero, 5'd0));
        emit('0);
        // Word and byte round trips through memory at 0x100
        start_program(4, 32'h8700_8a8a);
        emit(i_op(opc_lui, r_t0, r_zero, 16'h8765));
        emit(i_op(opc_ori, r_t0, r_t0, 16'h4321));
        emit(i_op(opc_sw, r_t0, r_zero, 16'h0100));
        emit(i_op(opc_addiu, r_t1, r_zero, 16'h00ab));
        emit(i_op(opc_sb, r_t1, r_zero, 16'h0102));
        emit(i_op(opc_lw, r_t2, r_zero, 16'h0100));
        emit(i_op(opc_lbu, r_t3, r_zero, 16'h0101));
        emit(i_op(opc_lbu, r_t4, r_zero, 16'h0103));
        emit(i_op(opc_lbu, r_t5, r_zero, 16'h0102));
        emit(r_op(fn_sll, r_t3, r_zero, r_t3, 5'd16));
        emit(r_op(fn_sll, r_t4, r_zero, r_t4, 5'd8));
        emit(r_op(fn_addu, reg_v0, r_t3, r_t4, 5'd0));
        emit(r_op(fn_addu, reg_v0, reg_v0, r_t5, 5'd0));
        emit(r_op(fn_xor, reg_v0, reg_v0, r_t2, 5'd0));
        emit(r_op(fn_jr, r_zero, r_zero, r_zero, 5'd0));
        emit('0);
    endtask

    task automatic run_test(input int t, input logic with_stalls);
        int cycles;
        u_mem.fill_pattern();
        for (int i = 0; i < prog_words; i++) begin
            u_mem.load_word(i, prog[t][i]);
        end
        stall_en = with_stalls;
        u_clk_gen.apply_reset();
        assert (active === 1'b1 && write === 1'b0)
            else stop_on_error($sformatf("test %0d: DUT inactive or writing after reset", t));
        cycles = 0;
        while (active === 1'b1 && cycles < halt_timeout) begin
            @(negedge clk);
            cycles++;
        end
        assert (active === 1'b0)
            else stop_on_error($sformatf("timeout: test %0d did not halt within %0d cycles",
                                         t, halt_timeout));
        assert (register_v0 === expected_v0[t])
            else stop_on_error($sformatf(
                "mismatch at time %0t: test %0d stalls %0b v0 %h expected %h",
                $time, t, with_stalls, register_v0, expected_v0[t]));
        // Halted core stays off the bus
        repeat (quiet_cycles) begin
            @(negedge clk);
            assert (read === 1'b0 && write === 1'b0 && active === 1'b0)
                else stop_on_error($sformatf("test %0d: bus strobe or activity after halt", t));
        end
    endtask

    // The memory model raises its flag on the falling edge
    always @(posedge clk) begin
        assert (bus_error !== 1'b1)
            else stop_on_error("memory model reported a bus protocol error");
    end

    initial begin
        stall_en = 1'b0;
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t, 1'b0);
            run_test(t, 1'b1);
        end
        $display("Verification passed");
        $finish;
    end

endmodule
